// File: verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

`define RV_RESET_PC   32'h0000_0000
`define RV_NUM_REGS   32
`define RV_SEL_W      4
`define RV_WAIT_LIMIT 32'd64

`endif

// File: verilog/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [`RV_SEL_W-1:0] sel_t;

	typedef enum logic [1:0] {
		FETCH,
		EXEC,
		MEM,
		RETIRE
	} core_state_t;

	// major opcodes of the supported subset
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;

endpackage

// File: verilog/exu_if.sv
interface exu_if;
	import rv_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	word_t src1;
	word_t src2;
	word_t imm;
	word_t pc;

	word_t val;
	logic taken;
	word_t target;
	logic mem_req;
	logic mem_we;
	word_t mem_addr;
	word_t mem_wdata;
	sel_t mem_sel;

	modport idu (output opcode, funct3, funct7, src1, src2, imm, pc);
	modport exu (input opcode, funct3, funct7, src1, src2, imm, pc,
		output val, taken, target, mem_req, mem_we, mem_addr, mem_wdata, mem_sel);
	modport ctrl (input taken, target, mem_req, mem_we, mem_addr, mem_wdata, mem_sel);

endinterface

// File: verilog/idu.sv
`include "rv_config.svh"

module idu (
	input logic clk,
	input logic arst_n,
	input rv_pkg::word_t instr,
	input rv_pkg::word_t pc,
	input logic wr_en,
	input rv_pkg::reg_idx_t wr_idx,
	input rv_pkg::word_t wr_data,
	output rv_pkg::reg_idx_t rd_idx,
	exu_if.idu eif
);
	import rv_pkg::*;

	word_t regs [`RV_NUM_REGS];
	reg_idx_t rs1;
	reg_idx_t rs2;

	assign eif.opcode = instr[6:0];
	assign eif.funct3 = instr[14:12];
	assign eif.funct7 = instr[31:25];
	assign eif.pc = pc;
	assign rd_idx = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	always_comb begin
		case (eif.opcode)
			OP_IMM, OP_LOAD, OP_JALR: eif.imm = {{20{instr[31]}}, instr[31:20]};
			OP_STORE: eif.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			OP_BRANCH: eif.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			OP_LUI, OP_AUIPC: eif.imm = {instr[31:12], 12'b0};
			OP_JAL: eif.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: eif.imm = '0;
		endcase
	end

	// x0 is never written so it keeps its reset zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign eif.src1 = regs[rs1]; // async read
	assign eif.src2 = regs[rs2];

endmodule

// File: verilog/exu.sv
module exu (
	exu_if.exu eif,
	input rv_pkg::word_t load_data
);
	import rv_pkg::*;

	word_t val0;
	word_t val1;
	word_t val2;
	word_t addr;
	word_t lbu_val;
	logic [4:0] shamt_i;
	logic [4:0] shamt_r;
	logic slt_rr;
	logic sltiu_ri;

	assign addr = eif.src1 + eif.imm;
	assign lbu_val = (load_data >> {addr[1:0], 3'b000}) & 32'hff;
	assign shamt_i = eif.imm[4:0];
	assign shamt_r = eif.src2[4:0];
	assign slt_rr = $signed(eif.src1) < $signed(eif.src2);
	assign sltiu_ri = eif.src1 < eif.imm;

	always_comb begin
		case (eif.opcode)
			OP_LUI: val0 = eif.imm;
			OP_AUIPC: val0 = eif.pc + eif.imm;
			OP_JAL: val0 = eif.pc + 32'd4; // link
			default: val0 = '0;
		endcase
	end

	always_comb begin
		case ({eif.funct3, eif.opcode})
			{3'b010, OP_LOAD}: val1 = load_data; // lw
			{3'b100, OP_LOAD}: val1 = lbu_val; // lbu
			{3'b000, OP_IMM}: val1 = addr; // addi
			{3'b011, OP_IMM}: val1 = {31'b0, sltiu_ri};
			{3'b100, OP_IMM}: val1 = eif.src1 ^ eif.imm;
			{3'b111, OP_IMM}: val1 = eif.src1 & eif.imm;
			{3'b000, OP_JALR}: val1 = eif.pc + 32'd4;
			default: val1 = '0;
		endcase
	end

	always_comb begin
		case ({eif.funct7, eif.funct3, eif.opcode})
			{7'h00, 3'b001, OP_IMM}: val2 = eif.src1 << shamt_i; // slli
			{7'h00, 3'b101, OP_IMM}: val2 = eif.src1 >> shamt_i; // srli
			{7'h20, 3'b101, OP_IMM}: val2 = $signed(eif.src1) >>> shamt_i; // srai
			{7'h00, 3'b000, OP_REG}: val2 = eif.src1 + eif.src2;
			{7'h20, 3'b000, OP_REG}: val2 = eif.src1 - eif.src2;
			{7'h00, 3'b001, OP_REG}: val2 = eif.src1 << shamt_r;
			{7'h00, 3'b010, OP_REG}: val2 = {31'b0, slt_rr};
			{7'h00, 3'b011, OP_REG}: val2 = {31'b0, eif.src1 < eif.src2}; // sltu
			{7'h00, 3'b100, OP_REG}: val2 = eif.src1 ^ eif.src2;
			{7'h00, 3'b110, OP_REG}: val2 = eif.src1 | eif.src2;
			{7'h00, 3'b111, OP_REG}: val2 = eif.src1 & eif.src2;
			default: val2 = '0;
		endcase
	end

	// at most one key table hits
	assign eif.val = val0 | val1 | val2;

	always_comb begin
		eif.taken = 1'b0;
		eif.target = eif.pc + eif.imm; // jal and branches
		if (eif.opcode == OP_JAL) begin
			eif.taken = 1'b1;
		end else begin
			case ({eif.funct3, eif.opcode})
				{3'b000, OP_JALR}: begin
					eif.taken = 1'b1;
					eif.target = addr & ~32'b1;
				end
				{3'b000, OP_BRANCH}: eif.taken = eif.src1 == eif.src2; // beq
				{3'b001, OP_BRANCH}: eif.taken = eif.src1 != eif.src2; // bne
				{3'b101, OP_BRANCH}: eif.taken = !slt_rr; // bge
				{3'b110, OP_BRANCH}: eif.taken = eif.src1 < eif.src2; // bltu
				{3'b111, OP_BRANCH}: eif.taken = eif.src1 >= eif.src2; // bgeu
				default: eif.taken = 1'b0;
			endcase
		end
	end

	assign eif.mem_addr = addr;
	assign eif.mem_wdata = eif.src2 << {addr[1:0], 3'b000}; // lane aligned

	always_comb begin
		eif.mem_req = 1'b1;
		eif.mem_we = 1'b0;
		case ({eif.funct3, eif.opcode})
			{3'b010, OP_LOAD}: eif.mem_sel = 4'b1111;
			{3'b100, OP_LOAD}: eif.mem_sel = sel_t'(4'b0001 << addr[1:0]);
			{3'b000, OP_STORE}: begin
				eif.mem_we = 1'b1;
				eif.mem_sel = sel_t'(4'b0001 << addr[1:0]); // sb
			end
			{3'b001, OP_STORE}: begin
				eif.mem_we = 1'b1;
				eif.mem_sel = sel_t'(4'b0011 << addr[1:0]); // sh
			end
			{3'b010, OP_STORE}: begin
				eif.mem_we = 1'b1;
				eif.mem_sel = 4'b1111; // sw
			end
			default: begin
				eif.mem_req = 1'b0;
				eif.mem_sel = '0;
			end
		endcase
	end

endmodule

// File: verilog/core_ctrl.sv
`include "rv_config.svh"

module core_ctrl (
	input logic clk,
	input logic arst_n,
	exu_if.ctrl eif,
	input rv_pkg::word_t exu_val,
	input rv_pkg::reg_idx_t rd_idx,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output rv_pkg::word_t wb_adr,
	output rv_pkg::word_t wb_dat_o,
	output rv_pkg::sel_t wb_sel,
	input rv_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output rv_pkg::word_t instr,
	output rv_pkg::word_t pc,
	output rv_pkg::word_t load_data,
	output logic wr_en,
	output rv_pkg::reg_idx_t wr_idx,
	output rv_pkg::word_t wr_data,
	output logic retire_valid,
	output logic bus_wait,
	output logic retire
);
	import rv_pkg::*;

	core_state_t state;

	// true for the supported encodings that have an rd
	function automatic logic writes_rd(word_t ins);
		funct3_t f3;
		funct7_t f7;
		f3 = ins[14:12];
		f7 = ins[31:25];
		case (opcode_t'(ins[6:0]))
			OP_LUI, OP_AUIPC, OP_JAL: return 1'b1;
			OP_JALR: return f3 == 3'b000;
			OP_LOAD: return f3 == 3'b010 || f3 == 3'b100;
			OP_IMM: begin
				if (f3 == 3'b001) return f7 == 7'h00;
				if (f3 == 3'b101) return f7 == 7'h00 || f7 == 7'h20;
				return f3 != 3'b010 && f3 != 3'b110;
			end
			OP_REG: begin
				if (f7 == 7'h20) return f3 == 3'b000; // sub
				return f7 == 7'h00 && f3 != 3'b101;
			end
			default: return 1'b0;
		endcase
	endfunction

	assign wb_stb = wb_cyc;
	assign bus_wait = wb_cyc && !wb_ack;
	assign retire = state == RETIRE;
	assign retire_valid = retire;
	assign wr_en = retire && writes_rd(instr);
	assign wr_idx = rd_idx;
	assign wr_data = exu_val;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= FETCH;
			pc <= `RV_RESET_PC;
			wb_cyc <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					if (!wb_cyc) begin
						wb_cyc <= 1'b1; // start instruction read
						wb_we <= 1'b0;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						state <= EXEC;
					end
				end
				EXEC: begin
					if (eif.mem_req) begin
						wb_cyc <= 1'b1;
						wb_we <= eif.mem_we;
						state <= MEM;
					end else begin
						state <= RETIRE;
					end
				end
				MEM: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_we <= 1'b0;
						state <= RETIRE;
					end
				end
				RETIRE: begin
					pc <= eif.taken ? eif.target : pc + 32'd4;
					state <= FETCH;
				end
				default: state <= FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FETCH && !wb_cyc) begin
			wb_adr <= pc;
			wb_sel <= '1;
		end
		if (state == FETCH && wb_cyc && wb_ack) begin
			instr <= wb_dat_i;
		end
		if (state == EXEC && eif.mem_req) begin
			wb_adr <= eif.mem_addr;
			wb_dat_o <= eif.mem_wdata;
			wb_sel <= eif.mem_sel;
		end
		if (state == MEM && wb_ack) begin
			load_data <= wb_dat_i; // harmless on stores
		end
	end

endmodule

// File: verilog/retire_counter.sv
`include "rv_config.svh"

module retire_counter (
	input logic clk,
	input logic arst_n,
	input logic retire,
	input logic bus_wait,
	output rv_pkg::word_t instret,
	output rv_pkg::word_t cycles,
	output logic bus_timeout
);
	import rv_pkg::*;

	word_t wait_cnt; // length of the current bus wait

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			instret <= '0;
			cycles <= '0;
			wait_cnt <= '0;
			bus_timeout <= 1'b0;
		end else begin
			cycles <= cycles + 32'd1;
			if (retire) instret <= instret + 32'd1;
			if (!bus_wait) begin
				wait_cnt <= '0;
			end else if (wait_cnt >= `RV_WAIT_LIMIT) begin
				bus_timeout <= 1'b1; // sticky until reset
			end else begin
				wait_cnt <= wait_cnt + 32'd1;
			end
		end
	end

endmodule

// File: verilog/rv_core.sv
module rv_core (
	input logic clk,
	input logic arst_n,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output rv_pkg::word_t wb_adr,
	output rv_pkg::word_t wb_dat_o,
	output rv_pkg::sel_t wb_sel,
	input rv_pkg::word_t wb_dat_i,
	input logic wb_ack,
	output logic retire_valid,
	output rv_pkg::word_t retire_pc,
	output rv_pkg::reg_idx_t retire_rd,
	output rv_pkg::word_t retire_value,
	output logic retire_we,
	output rv_pkg::word_t instret,
	output rv_pkg::word_t cycles,
	output logic bus_timeout
);
	import rv_pkg::*;

	exu_if eif ();

	word_t instr;
	word_t pc;
	word_t load_data;
	logic wr_en;
	reg_idx_t wr_idx;
	word_t wr_data;
	reg_idx_t rd_idx;
	logic bus_wait;
	logic retire;

	idu u_idu (
		.clk(clk),
		.arst_n(arst_n),
		.instr(instr),
		.pc(pc),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.rd_idx(rd_idx),
		.eif(eif)
	);

	exu u_exu (
		.eif(eif),
		.load_data(load_data)
	);

	core_ctrl u_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.eif(eif),
		.exu_val(eif.val),
		.rd_idx(rd_idx),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.instr(instr),
		.pc(pc),
		.load_data(load_data),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_data(wr_data),
		.retire_valid(retire_valid),
		.bus_wait(bus_wait),
		.retire(retire)
	);

	retire_counter u_cnt (
		.clk(clk),
		.arst_n(arst_n),
		.retire(retire),
		.bus_wait(bus_wait),
		.instret(instret),
		.cycles(cycles),
		.bus_timeout(bus_timeout)
	);

	assign retire_pc = pc;
	assign retire_rd = wr_idx;
	assign retire_value = wr_data;
	assign retire_we = wr_en;

endmodule

// File: testbench/rv_core_checker.sv
module rv_core_checker (
	input logic clk,
	input logic arst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input rv_pkg::word_t wb_adr,
	input rv_pkg::word_t wb_dat_o,
	input rv_pkg::sel_t wb_sel,
	input logic wb_ack,
	input logic retire_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // read by the testbench

	stb_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb |-> wb_cyc)
	else begin
		fail_count++;
		$error("wb_stb high outside a bus cycle");
	end

	// write data only matters on writes
	request_stable: assert property (@(posedge clk) disable iff (!arst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_sel)
			&& (!wb_we || $stable(wb_dat_o)))
	else begin
		fail_count++;
		$error("bus request changed before ack");
	end

	retire_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |=> !retire_valid)
	else begin
		fail_count++;
		$error("retire_valid longer than one cycle");
	end

	retire_idle_bus: assert property (@(posedge clk) disable iff (!arst_n)
		!(retire_valid && wb_cyc))
	else begin
		fail_count++;
		$error("retire_valid during a bus cycle");
	end

endmodule

bind rv_core rv_core_checker u_checker (
	.clk(clk),
	.arst_n(arst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_we(wb_we),
	.wb_adr(wb_adr),
	.wb_dat_o(wb_dat_o),
	.wb_sel(wb_sel),
	.wb_ack(wb_ack),
	.retire_valid(retire_valid)
);

// File: testbench/tb_rv_core.sv
`include "rv_config.svh"

module tb_rv_core;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int MEM_WORDS = 1024;
	// worst case is 11 cycles per instruction with three wait states on both accesses
	localparam int TIMEOUT_CYCLES = PROG_LEN * 12;
	localparam word_t HALT_PC = word_t'(4 * (PROG_LEN - 1));

	logic clk;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	word_t wb_adr;
	word_t wb_dat_o;
	sel_t wb_sel;
	word_t wb_dat_i;
	logic wb_ack;
	logic retire_valid;
	word_t retire_pc;
	reg_idx_t retire_rd;
	word_t retire_value;
	logic retire_we;
	word_t instret;
	word_t cycles;
	logic bus_timeout;

	logic [31:0] lfsr = 32'h56a3;
	word_t mem [MEM_WORDS]; // bus side memory
	word_t ref_mem [MEM_WORDS];
	word_t ref_regs [`RV_NUM_REGS];
	word_t ref_pc;

	logic exp_we;
	word_t exp_val;
	reg_idx_t exp_rd;
	logic exp_store;
	word_t exp_addr;
	word_t exp_dat;
	sel_t exp_sel;

	logic st_seen;
	word_t st_adr;
	word_t st_dat;
	sel_t st_sel;

	int retire_count;
	int cycle_count;
	logic done;

	rv_core dut (
		.clk(clk),
		.arst_n(arst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_o(wb_dat_o),
		.wb_sel(wb_sel),
		.wb_dat_i(wb_dat_i),
		.wb_ack(wb_ack),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_value(retire_value),
		.retire_we(retire_we),
		.instret(instret),
		.cycles(cycles),
		.bus_timeout(bus_timeout)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic word_t lfsr_take(input int n);
		word_t r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hd000_0001 : lfsr >> 1;
		end
		return r;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			fail_run($sformatf("error %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			fail_run($sformatf("error %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_sel(input string name, input sel_t got, input sel_t exp);
		if (got !== exp) begin
			fail_run($sformatf("error %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_run($sformatf("error %s: got %h, expected %h", name, got, exp));
		end
	endtask

	function automatic word_t lane_mask(input sel_t s);
		word_t m;
		for (int k = 0; k < 4; k++) begin
			m[8*k +: 8] = s[k] ? 8'hff : 8'h00;
		end
		return m;
	endfunction

	function automatic word_t enc_branch(input word_t off, input reg_idx_t rs2,
		input reg_idx_t rs1, input funct3_t f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t enc_jal(input word_t off, input reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	// x1..x7 seeded, then random forward-only code, then a jal-to-self halt
	task automatic build_program();
		word_t ins;
		word_t rnd;
		word_t t;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic [3:0] kind;
		logic [2:0] pick;
		funct3_t f3;
		funct7_t f7;
		int fwd;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = word_t'(i) * 32'h9e37_79b1;
		end
		for (int r = 1; r < 8; r++) begin
			rnd = lfsr_take(20);
			mem[2*r-2] = {rnd[19:0], 5'(r), OP_LUI};
			rnd = lfsr_take(12);
			mem[2*r-1] = {rnd[11:0], 5'(r), 3'b000, 5'(r), OP_IMM};
		end
		for (int i = 14; i < PROG_LEN - 1; i++) begin
			kind = 4'(lfsr_take(4));
			rd = 5'(lfsr_take(3));
			rs1 = 5'(lfsr_take(3));
			rs2 = 5'(lfsr_take(3));
			fwd = 4 * (1 + int'(lfsr_take(2)));
			if (fwd > 4 * (PROG_LEN - 1 - i)) fwd = 4 * (PROG_LEN - 1 - i);
			case (kind)
				4'd0, 4'd1: begin
					rnd = lfsr_take(20);
					ins = {rnd[19:0], rd, (kind == 4'd0) ? OP_LUI : OP_AUIPC};
				end
				4'd2: ins = enc_jal(word_t'(fwd), rd);
				4'd3: begin
					rnd = lfsr_take(1);
					t = word_t'(4 * i + fwd) | rnd; // odd target, bit 0 must drop
					ins = {t[11:0], 5'd0, 3'b000, rd, OP_JALR};
				end
				4'd4, 4'd5: begin
					pick = 3'(lfsr_take(3));
					case (pick)
						3'd0, 3'd5: f3 = 3'b000;
						3'd1, 3'd6: f3 = 3'b001;
						3'd2: f3 = 3'b101;
						3'd3, 3'd7: f3 = 3'b110;
						default: f3 = 3'b111;
					endcase
					ins = enc_branch(word_t'(fwd), rs2, rs1, f3);
				end
				4'd6: begin
					rnd = lfsr_take(8);
					ins = {2'b01, rnd[7:0], 2'b00, 5'd0, 3'b010, rd, OP_LOAD};
				end
				4'd7: begin
					rnd = lfsr_take(10);
					ins = {2'b01, rnd[9:0], 5'd0, 3'b100, rd, OP_LOAD};
				end
				4'd8: begin
					pick = 3'(lfsr_take(2));
					if (pick == 3'd0) begin
						rnd = lfsr_take(10);
						t = {20'h0, 2'b01, rnd[9:0]};
						f3 = 3'b000;
					end else if (pick == 3'd1) begin
						rnd = lfsr_take(9);
						t = {20'h0, 2'b01, rnd[8:0], 1'b0};
						f3 = 3'b001;
					end else begin
						rnd = lfsr_take(8);
						t = {20'h0, 2'b01, rnd[7:0], 2'b00};
						f3 = 3'b010;
					end
					ins = {t[11:5], rs2, 5'd0, f3, t[4:0], OP_STORE};
				end
				4'd9, 4'd10, 4'd15: begin
					pick = 3'(lfsr_take(3));
					rnd = lfsr_take(12);
					f7 = 7'h00;
					case (pick)
						3'd1: f3 = 3'b011;
						3'd2: f3 = 3'b100;
						3'd3: f3 = 3'b111;
						3'd4: f3 = 3'b001;
						3'd5: f3 = 3'b101;
						3'd6: begin
							f3 = 3'b101;
							f7 = 7'h20;
						end
						default: f3 = 3'b000;
					endcase
					if (f3 == 3'b001 || f3 == 3'b101) begin
						ins = {f7, rnd[4:0], rs1, f3, rd, OP_IMM};
					end else begin
						ins = {rnd[11:0], rs1, f3, rd, OP_IMM};
					end
				end
				4'd11, 4'd12, 4'd13: begin
					pick = 3'(lfsr_take(3));
					f7 = (pick == 3'd1) ? 7'h20 : 7'h00;
					case (pick)
						3'd0, 3'd1: f3 = 3'b000;
						3'd2: f3 = 3'b001;
						3'd3: f3 = 3'b010;
						3'd4: f3 = 3'b011;
						3'd5: f3 = 3'b100;
						3'd6: f3 = 3'b110;
						default: f3 = 3'b111;
					endcase
					ins = {f7, rs2, rs1, f3, rd, OP_REG};
				end
				default: begin
					rnd = lfsr_take(25);
					ins = {rnd[24:0], 7'b0001111}; // fence space, not decoded
				end
			endcase
			mem[i] = ins;
		end
		mem[PROG_LEN-1] = enc_jal('0, '0); // halt
		ref_mem = mem;
	endtask

	// ISA level model of one instruction
	function automatic void ref_step(input word_t ins);
		opcode_t op;
		funct3_t f3;
		funct7_t f7;
		reg_idx_t rd;
		word_t a;
		word_t b;
		word_t i_imm;
		word_t s_imm;
		word_t b_imm;
		word_t ea;
		word_t next_pc;
		logic taken;
		op = ins[6:0];
		f3 = ins[14:12];
		f7 = ins[31:25];
		rd = ins[11:7];
		exp_rd = rd;
		a = ref_regs[ins[19:15]];
		b = ref_regs[ins[24:20]];
		i_imm = {{20{ins[31]}}, ins[31:20]};
		s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		b_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		exp_we = 1'b0;
		exp_val = '0;
		exp_store = 1'b0;
		next_pc = ref_pc + 32'd4;
		case (op)
			OP_LUI: {exp_we, exp_val} = {1'b1, ins[31:12], 12'h000};
			OP_AUIPC: {exp_we, exp_val} = {1'b1, ref_pc + {ins[31:12], 12'h000}};
			OP_JAL: begin
				{exp_we, exp_val} = {1'b1, ref_pc + 32'd4};
				next_pc = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
					ins[30:21], 1'b0};
			end
			OP_JALR: if (f3 == 3'b000) begin
				{exp_we, exp_val} = {1'b1, ref_pc + 32'd4};
				next_pc = (a + i_imm) & ~32'd1;
			end
			OP_BRANCH: begin
				case (f3)
					3'b000: taken = a == b;
					3'b001: taken = a != b;
					3'b101: taken = $signed(a) >= $signed(b);
					3'b110: taken = a < b;
					3'b111: taken = a >= b;
					default: taken = 1'b0; // blt and friends are not decoded
				endcase
				if (taken) next_pc = ref_pc + b_imm;
			end
			OP_LOAD: begin
				ea = a + i_imm;
				if (f3 == 3'b010) {exp_we, exp_val} = {1'b1, ref_mem[ea[11:2]]};
				if (f3 == 3'b100) begin
					{exp_we, exp_val} = {1'b1, (ref_mem[ea[11:2]] >> (8 * ea[1:0])) & 32'hff};
				end
			end
			OP_STORE: begin
				ea = a + s_imm;
				exp_store = 1'b1;
				exp_addr = ea;
				exp_dat = b << (8 * ea[1:0]);
				case (f3)
					3'b000: exp_sel = sel_t'(4'b0001 << ea[1:0]);
					3'b001: exp_sel = sel_t'(4'b0011 << ea[1:0]);
					3'b010: exp_sel = 4'b1111;
					default: exp_store = 1'b0;
				endcase
				for (int k = 0; k < 4; k++) begin
					if (exp_store && exp_sel[k]) ref_mem[ea[11:2]][8*k +: 8] = exp_dat[8*k +: 8];
				end
			end
			OP_IMM: begin
				exp_we = 1'b1;
				case (f3)
					3'b000: exp_val = a + i_imm;
					3'b011: exp_val = {31'b0, a < i_imm};
					3'b100: exp_val = a ^ i_imm;
					3'b111: exp_val = a & i_imm;
					3'b001: begin
						exp_we = f7 == 7'h00;
						exp_val = a << ins[24:20];
					end
					3'b101: begin
						exp_we = f7 == 7'h00 || f7 == 7'h20;
						if (f7 == 7'h20) begin
							exp_val = $signed(a) >>> ins[24:20];
						end else begin
							exp_val = a >> ins[24:20];
						end
					end
					default: exp_we = 1'b0;
				endcase
			end
			OP_REG: begin
				exp_we = 1'b1;
				case ({f7, f3})
					{7'h00, 3'b000}: exp_val = a + b;
					{7'h20, 3'b000}: exp_val = a - b;
					{7'h00, 3'b001}: exp_val = a << b[4:0];
					{7'h00, 3'b010}: exp_val = {31'b0, $signed(a) < $signed(b)};
					{7'h00, 3'b011}: exp_val = {31'b0, a < b};
					{7'h00, 3'b100}: exp_val = a ^ b;
					{7'h00, 3'b110}: exp_val = a | b;
					{7'h00, 3'b111}: exp_val = a & b;
					default: exp_we = 1'b0;
				endcase
			end
			default: exp_we = 1'b0;
		endcase
		if (exp_we && rd != '0) ref_regs[rd] = exp_val;
		ref_pc = next_pc;
	endfunction

	// wishbone slave with 0 to 3 wait states
	initial begin
		int delay;
		delay = -1;
		forever begin
			@(posedge clk);
			#5;
			if (wb_ack) begin
				wb_ack = 1'b0;
			end else if (arst_n && wb_cyc && wb_stb) begin
				if (wb_adr[31:12] != '0) fail_run("bus access outside the 4 KB memory");
				if (delay < 0) delay = int'(lfsr_take(2));
				if (delay == 0) begin
					if (wb_we) begin
						for (int k = 0; k < 4; k++) begin
							if (wb_sel[k]) mem[wb_adr[11:2]][8*k +: 8] = wb_dat_o[8*k +: 8];
						end
						{st_seen, st_adr, st_dat, st_sel} = {1'b1, wb_adr, wb_dat_o, wb_sel};
					end else begin
						wb_dat_i = mem[wb_adr[11:2]];
					end
					wb_ack = 1'b1;
					delay = -1;
				end else begin
					delay--;
				end
			end
		end
	end

	// compare each retire against the model
	always @(negedge clk) begin
		if (arst_n && retire_valid && !done) begin
			check_word("retire_pc", retire_pc, ref_pc);
			ref_step(ref_mem[ref_pc[11:2]]);
			check_flag("retire_we", retire_we, exp_we);
			if (exp_we) begin
				check_idx("retire_rd", retire_rd, exp_rd);
				check_word("retire_value", retire_value, exp_val);
			end
			if (exp_store) begin
				if (!st_seen) fail_run("store retired without a bus write");
				check_word("wb_adr", st_adr, exp_addr);
				check_sel("wb_sel", st_sel, exp_sel);
				check_word("wb_dat_o", st_dat & lane_mask(st_sel), exp_dat & lane_mask(exp_sel));
			end else if (st_seen) begin
				fail_run("bus write during an instruction that is not a store");
			end
			st_seen = 1'b0;
			check_flag("bus_timeout", bus_timeout, 1'b0);
			if (dut.u_checker.fail_count != 0) fail_run("bus protocol assertion failed");
			retire_count++;
			if (retire_pc == HALT_PC) done = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (arst_n) begin
			cycle_count++;
			if (cycle_count > TIMEOUT_CYCLES) begin
				fail_run($sformatf("timeout, halt not reached within %0d cycles", TIMEOUT_CYCLES));
			end
		end
	end

	initial begin
		arst_n = 1'b0;
		wb_dat_i = '0;
		wb_ack = 1'b0;
		st_seen = 1'b0;
		done = 1'b0;
		retire_count = 0;
		cycle_count = 0;
		ref_pc = `RV_RESET_PC;
		for (int r = 0; r < `RV_NUM_REGS; r++) begin
			ref_regs[r] = '0;
		end
		build_program();
		repeat (8) @(posedge clk);
		#5;
		arst_n = 1'b1;
		wait (wb_cyc === 1'b1);
		#1;
		check_word("wb_adr", wb_adr, `RV_RESET_PC); // first fetch
		wait (done);
		@(posedge clk);
		#5;
		check_word("instret", instret, word_t'(retire_count));
		if (cycles < instret * 3) fail_run("cycle counter is below three cycles per instruction");
		check_flag("bus_timeout", bus_timeout, 1'b0);
		if (dut.u_checker.fail_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			fail_run("bus protocol assertion failed");
		end
	end

endmodule

// File: src.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/exu_if.sv
verilog/idu.sv
verilog/exu.sv
verilog/core_ctrl.sv
verilog/retire_counter.sv
verilog/rv_core.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/exu_if.sv
      - verilog/idu.sv
      - verilog/exu.sv
      - verilog/core_ctrl.sv
      - verilog/retire_counter.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/rv_core_checker.sv
      - testbench/tb_rv_core.sv
